// ==== soc_defs.svh ====
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

// Near regions from address bits 31..28
`define SOC_REGION_RAM       4'd2
`define SOC_REGION_BRIDGE    4'd5

// Far regions from address bits 27..24
`define SOC_FAR_TIMER        4'd5
`define SOC_FAR_IRQ          4'd8
`define SOC_FAR_SYSREG       4'd9

// On-chip RAM depth in words
`define SOC_RAM_WORDS        256

`define SOC_DEVICE_ID        32'd6

// Timer registers
`define SOC_TIMER_COUNTER    4'd0
`define SOC_TIMER_COMPARE    4'd1

// Interrupt controller registers
`define SOC_IRQ_PENDING      4'd0
`define SOC_IRQ_ENABLE       4'd1

// System registers
`define SOC_SYSREG_ID        4'd0
`define SOC_SYSREG_RAM_SIZE  4'd1
`define SOC_SYSREG_LEDS      4'd2
`define SOC_SYSREG_SCRATCH   4'd3

`endif

// ==== soc_pkg.sv ====
`default_nettype none

package soc_pkg;

	// Bus address or data word
	typedef logic [31:0] word_t;

	// Near side uses bits 31..28, far side bits 27..24
	typedef logic [3:0] region_t;

	// Register index from address bits 5..2
	typedef logic [3:0] reg_index_t;

	// Bit 0 timer, bit 1 external input
	typedef logic [1:0] irq_vec_t;

endpackage

`default_nettype wire

// ==== bus_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module bus_arbiter (
	input wire clock,
	input wire i_rst_n,

	// Port A, instruction reads only
	input wire i_ia_request,
	input wire soc_pkg::word_t i_ia_address,
	output logic o_ia_ready,
	output soc_pkg::word_t o_ia_rdata,

	// Port B, data
	input wire i_db_request,
	input wire i_db_rw,
	input wire soc_pkg::word_t i_db_address,
	input wire soc_pkg::word_t i_db_wdata,
	output logic o_db_ready,
	output soc_pkg::word_t o_db_rdata,

	// System bus
	output logic o_bus_request,
	output logic o_bus_rw,
	output soc_pkg::word_t o_bus_address,
	output soc_pkg::word_t o_bus_wdata,
	input wire soc_pkg::word_t i_bus_rdata,
	input wire i_bus_ready
);

	typedef enum logic [1:0] {
		st_idle,
		st_busy_a,
		st_busy_b
	} state_t;

	state_t state;
	logic grant_a, grant_b;

	// A master still holds request in its ready cycle
	assign grant_b = state == st_idle && i_db_request && !o_db_ready;
	assign grant_a = state == st_idle && i_ia_request && !o_ia_ready && !grant_b;

	always_ff @(posedge clock) begin
		if (!i_rst_n) begin
			state <= st_idle;
			o_bus_request <= 1'b0;
			o_ia_ready <= 1'b0;
			o_db_ready <= 1'b0;
		end else begin
			o_ia_ready <= state == st_busy_a && i_bus_ready;
			o_db_ready <= state == st_busy_b && i_bus_ready;
			if (grant_b) begin
				state <= st_busy_b;
				o_bus_request <= 1'b1;
			end else if (grant_a) begin
				state <= st_busy_a;
				o_bus_request <= 1'b1;
			end else if (state != st_idle && i_bus_ready) begin
				state <= st_idle;
				o_bus_request <= 1'b0;
			end
		end
	end

	// Latch the granted transfer and the returned word
	always_ff @(posedge clock) begin
		if (grant_b) begin
			o_bus_rw <= i_db_rw;
			o_bus_address <= i_db_address;
			o_bus_wdata <= i_db_wdata;
		end else if (grant_a) begin
			o_bus_rw <= 1'b0;
			o_bus_address <= i_ia_address;
			o_bus_wdata <= '0;
		end
		if (state == st_busy_a && i_bus_ready)
			o_ia_rdata <= i_bus_rdata;
		if (state == st_busy_b && i_bus_ready)
			o_db_rdata <= i_bus_rdata;
	end

endmodule

`default_nettype wire

// ==== near_bus.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "soc_defs.svh"

module near_bus #(
	parameter int RAM_WORDS = `SOC_RAM_WORDS
) (
	input wire clock,
	input wire i_rst_n,

	input wire i_bus_request,
	input wire i_bus_rw,
	input wire soc_pkg::word_t i_bus_address,
	input wire soc_pkg::word_t i_bus_wdata,
	output soc_pkg::word_t o_bus_rdata,
	output logic o_bus_ready,

	output logic o_bridge_request,
	output logic o_bridge_rw,
	output logic [27:0] o_bridge_address,
	output soc_pkg::word_t o_bridge_wdata,
	input wire soc_pkg::word_t i_bridge_rdata,
	input wire i_bridge_ready
);

	// Power of two depth, so the index wraps modulo RAM_WORDS
	localparam int IDX_W = $clog2(RAM_WORDS);

	soc_pkg::region_t region;
	logic ram_sel, bridge_sel, local_start, local_ready;
	logic [IDX_W-1:0] ram_index;
	soc_pkg::word_t local_rdata;
	soc_pkg::word_t ram [RAM_WORDS];

	assign region = i_bus_address[31:28];
	assign ram_sel = region == `SOC_REGION_RAM;
	assign bridge_sel = region == `SOC_REGION_BRIDGE;
	assign ram_index = i_bus_address[2 +: IDX_W];

	// RAM and unmapped regions answer locally
	assign local_start = i_bus_request && !bridge_sel && !local_ready;

	always_ff @(posedge clock) begin
		if (!i_rst_n)
			local_ready <= 1'b0;
		else
			local_ready <= local_start;
	end

	always_ff @(posedge clock) begin
		if (local_start && ram_sel && i_bus_rw)
			ram[ram_index] <= i_bus_wdata;
		if (local_start)
			local_rdata <= ram_sel ? ram[ram_index] : '0;
	end

	assign o_bridge_request = i_bus_request && bridge_sel;
	assign o_bridge_rw = i_bus_rw;
	assign o_bridge_address = i_bus_address[27:0];
	assign o_bridge_wdata = i_bus_wdata;

	assign o_bus_rdata = bridge_sel ? i_bridge_rdata : local_rdata;
	assign o_bus_ready = bridge_sel ? i_bridge_ready : local_ready;

endmodule

`default_nettype wire

// ==== far_bridge.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "soc_defs.svh"

module far_bridge (
	input wire clock,
	input wire i_rst_n,

	// Near side
	input wire i_request,
	input wire i_rw,
	input wire [27:0] i_address,
	input wire soc_pkg::word_t i_wdata,
	output soc_pkg::word_t o_rdata,
	output logic o_ready,

	// Far side, shared by all peripherals
	output logic o_far_rw,
	output soc_pkg::reg_index_t o_far_index,
	output soc_pkg::word_t o_far_wdata,

	output logic o_timer_request,
	input wire soc_pkg::word_t i_timer_rdata,
	input wire i_timer_ready,

	output logic o_irq_request,
	input wire soc_pkg::word_t i_irq_rdata,
	input wire i_irq_ready,

	output logic o_sysreg_request,
	input wire soc_pkg::word_t i_sysreg_rdata,
	input wire i_sysreg_ready
);

	soc_pkg::region_t region_r;
	logic far_request_r, start, unmapped_ready;
	logic timer_sel, irq_sel, sysreg_sel, unmapped_sel;
	logic far_ready;
	soc_pkg::word_t far_rdata;

	// Near request stays up through our ready cycle
	assign start = i_request && !far_request_r && !o_ready;

	assign timer_sel = region_r == `SOC_FAR_TIMER;
	assign irq_sel = region_r == `SOC_FAR_IRQ;
	assign sysreg_sel = region_r == `SOC_FAR_SYSREG;
	assign unmapped_sel = !(timer_sel || irq_sel || sysreg_sel);

	assign o_timer_request = far_request_r && timer_sel;
	assign o_irq_request = far_request_r && irq_sel;
	assign o_sysreg_request = far_request_r && sysreg_sel;

	assign far_rdata =
		timer_sel  ? i_timer_rdata  :
		irq_sel    ? i_irq_rdata    :
		sysreg_sel ? i_sysreg_rdata :
		'0;

	assign far_ready =
		timer_sel  ? i_timer_ready  :
		irq_sel    ? i_irq_ready    :
		sysreg_sel ? i_sysreg_ready :
		unmapped_ready;

	always_ff @(posedge clock) begin
		if (!i_rst_n) begin
			far_request_r <= 1'b0;
			unmapped_ready <= 1'b0;
			o_ready <= 1'b0;
		end else begin
			o_ready <= far_request_r && far_ready;
			unmapped_ready <= far_request_r && unmapped_sel && !unmapped_ready;
			if (start)
				far_request_r <= 1'b1;
			else if (far_ready)
				far_request_r <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (start) begin
			region_r <= i_address[27:24];
			o_far_index <= i_address[5:2];
			o_far_rw <= i_rw;
			o_far_wdata <= i_wdata;
		end
		if (far_request_r && far_ready)
			o_rdata <= far_rdata;
	end

endmodule

`default_nettype wire

// ==== interval_timer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "soc_defs.svh"

module interval_timer (
	input wire clock,
	input wire i_rst_n,

	input wire i_request,
	input wire i_rw,
	input wire soc_pkg::reg_index_t i_index,
	input wire soc_pkg::word_t i_wdata,
	output soc_pkg::word_t o_rdata,
	output logic o_ready,

	output logic o_irq
);

	soc_pkg::word_t counter, compare;
	logic access, write;

	assign access = i_request && !o_ready;
	assign write = access && i_rw;

	always_ff @(posedge clock) begin
		if (!i_rst_n) begin
			counter <= '0;
			compare <= '0;
			o_irq <= 1'b0;
			o_ready <= 1'b0;
		end else begin
			o_ready <= access;
			if (write && i_index == `SOC_TIMER_COUNTER)
				counter <= i_wdata;
			else
				counter <= counter + 32'd1;
			// Irq holds until compare is rewritten
			if (write && i_index == `SOC_TIMER_COMPARE) begin
				compare <= i_wdata;
				o_irq <= 1'b0;
			end else if (compare != '0 && counter == compare) begin
				o_irq <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (access) begin
			case (i_index)
				`SOC_TIMER_COUNTER: o_rdata <= counter;
				`SOC_TIMER_COMPARE: o_rdata <= compare;
				default:            o_rdata <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== interrupt_controller.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "soc_defs.svh"

module interrupt_controller (
	input wire clock,
	input wire i_rst_n,

	input wire i_request,
	input wire i_rw,
	input wire soc_pkg::reg_index_t i_index,
	input wire soc_pkg::word_t i_wdata,
	output soc_pkg::word_t o_rdata,
	output logic o_ready,

	input wire soc_pkg::irq_vec_t i_sources,
	output logic o_interrupt
);

	soc_pkg::irq_vec_t sources_q, rising, pending, enable, clear;
	logic access, write;

	assign access = i_request && !o_ready;
	assign write = access && i_rw;

	// Edge detect on each source
	assign rising = i_sources & ~sources_q;

	// Write one to clear
	assign clear = (write && i_index == `SOC_IRQ_PENDING) ? i_wdata[1:0] : 2'b00;

	always_ff @(posedge clock) begin
		if (!i_rst_n) begin
			sources_q <= '0;
			pending <= '0;
			enable <= '0;
			o_ready <= 1'b0;
		end else begin
			o_ready <= access;
			sources_q <= i_sources;
			pending <= (pending & ~clear) | rising;
			if (write && i_index == `SOC_IRQ_ENABLE)
				enable <= i_wdata[1:0];
		end
	end

	always_ff @(posedge clock) begin
		if (access) begin
			case (i_index)
				`SOC_IRQ_PENDING: o_rdata <= {30'd0, pending};
				`SOC_IRQ_ENABLE:  o_rdata <= {30'd0, enable};
				default:          o_rdata <= '0;
			endcase
		end
	end

	assign o_interrupt = |(pending & enable);

endmodule

`default_nettype wire

// ==== system_registers.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "soc_defs.svh"

module system_registers (
	input wire clock,
	input wire i_rst_n,

	input wire i_request,
	input wire i_rw,
	input wire soc_pkg::reg_index_t i_index,
	input wire soc_pkg::word_t i_wdata,
	output soc_pkg::word_t o_rdata,
	output logic o_ready,

	output logic [7:0] o_leds
);

	soc_pkg::word_t scratch;
	logic access, write;

	assign access = i_request && !o_ready;
	assign write = access && i_rw;

	// Id and RAM size are constants
	always_ff @(posedge clock) begin
		if (!i_rst_n) begin
			o_leds <= 8'd0;
			o_ready <= 1'b0;
		end else begin
			o_ready <= access;
			if (write && i_index == `SOC_SYSREG_LEDS)
				o_leds <= i_wdata[7:0];
		end
	end

	always_ff @(posedge clock) begin
		if (write && i_index == `SOC_SYSREG_SCRATCH)
			scratch <= i_wdata;
		if (access) begin
			case (i_index)
				`SOC_SYSREG_ID:       o_rdata <= `SOC_DEVICE_ID;
				`SOC_SYSREG_RAM_SIZE: o_rdata <= 32'(`SOC_RAM_WORDS * 4);
				`SOC_SYSREG_LEDS:     o_rdata <= {24'd0, o_leds};
				`SOC_SYSREG_SCRATCH:  o_rdata <= scratch;
				default:              o_rdata <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== soc_fabric.sv ====
`timescale 1ns/10ps
`default_nettype none

module soc_fabric (
	input wire clock,
	input wire i_rst_n,

	input wire i_ia_request,
	input wire soc_pkg::word_t i_ia_address,
	output logic o_ia_ready,
	output soc_pkg::word_t o_ia_rdata,

	input wire i_db_request,
	input wire i_db_rw,
	input wire soc_pkg::word_t i_db_address,
	input wire soc_pkg::word_t i_db_wdata,
	output logic o_db_ready,
	output soc_pkg::word_t o_db_rdata,

	input wire i_ext_irq,
	output logic o_interrupt,
	output logic [7:0] o_leds
);

	// ========================================
	// System bus
	// ========================================

	logic bus_request, bus_rw, bus_ready;
	soc_pkg::word_t bus_address, bus_wdata, bus_rdata;

	bus_arbiter arbiter (
		.clock(clock), .i_rst_n(i_rst_n),
		.i_ia_request(i_ia_request), .i_ia_address(i_ia_address),
		.o_ia_ready(o_ia_ready), .o_ia_rdata(o_ia_rdata),
		.i_db_request(i_db_request), .i_db_rw(i_db_rw),
		.i_db_address(i_db_address), .i_db_wdata(i_db_wdata),
		.o_db_ready(o_db_ready), .o_db_rdata(o_db_rdata),
		.o_bus_request(bus_request), .o_bus_rw(bus_rw),
		.o_bus_address(bus_address), .o_bus_wdata(bus_wdata),
		.i_bus_rdata(bus_rdata), .i_bus_ready(bus_ready)
	);

	logic bridge_request, bridge_rw, bridge_ready;
	logic [27:0] bridge_address;
	soc_pkg::word_t bridge_wdata, bridge_rdata;

	near_bus near (
		.clock(clock), .i_rst_n(i_rst_n),
		.i_bus_request(bus_request), .i_bus_rw(bus_rw),
		.i_bus_address(bus_address), .i_bus_wdata(bus_wdata),
		.o_bus_rdata(bus_rdata), .o_bus_ready(bus_ready),
		.o_bridge_request(bridge_request), .o_bridge_rw(bridge_rw),
		.o_bridge_address(bridge_address), .o_bridge_wdata(bridge_wdata),
		.i_bridge_rdata(bridge_rdata), .i_bridge_ready(bridge_ready)
	);

	// ========================================
	// Peripheral side of the bridge
	// ========================================

	logic far_rw;
	soc_pkg::reg_index_t far_index;
	soc_pkg::word_t far_wdata;

	logic timer_request, timer_ready;
	logic irq_request, irq_ready;
	logic sysreg_request, sysreg_ready;
	soc_pkg::word_t timer_rdata, irq_rdata, sysreg_rdata;
	logic timer_irq;

	far_bridge bridge (
		.clock(clock), .i_rst_n(i_rst_n),
		.i_request(bridge_request), .i_rw(bridge_rw),
		.i_address(bridge_address), .i_wdata(bridge_wdata),
		.o_rdata(bridge_rdata), .o_ready(bridge_ready),
		.o_far_rw(far_rw), .o_far_index(far_index), .o_far_wdata(far_wdata),
		.o_timer_request(timer_request),
		.i_timer_rdata(timer_rdata), .i_timer_ready(timer_ready),
		.o_irq_request(irq_request),
		.i_irq_rdata(irq_rdata), .i_irq_ready(irq_ready),
		.o_sysreg_request(sysreg_request),
		.i_sysreg_rdata(sysreg_rdata), .i_sysreg_ready(sysreg_ready)
	);

	interval_timer timer (
		.clock(clock), .i_rst_n(i_rst_n),
		.i_request(timer_request), .i_rw(far_rw),
		.i_index(far_index), .i_wdata(far_wdata),
		.o_rdata(timer_rdata), .o_ready(timer_ready),
		.o_irq(timer_irq)
	);

	interrupt_controller irq_ctrl (
		.clock(clock), .i_rst_n(i_rst_n),
		.i_request(irq_request), .i_rw(far_rw),
		.i_index(far_index), .i_wdata(far_wdata),
		.o_rdata(irq_rdata), .o_ready(irq_ready),
		.i_sources({i_ext_irq, timer_irq}),
		.o_interrupt(o_interrupt)
	);

	system_registers sysreg (
		.clock(clock), .i_rst_n(i_rst_n),
		.i_request(sysreg_request), .i_rw(far_rw),
		.i_index(far_index), .i_wdata(far_wdata),
		.o_rdata(sysreg_rdata), .o_ready(sysreg_ready),
		.o_leds(o_leds)
	);

endmodule

`default_nettype wire

// ==== tb_soc_fabric.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "soc_defs.svh"

module tb_soc_fabric;

	localparam int MAX_STEPS = 64;

	typedef logic [8*32-1:0] tag_t;

	logic clock = 1'b0;
	logic rst_n;
	logic ia_request, ia_ready;
	soc_pkg::word_t ia_address, ia_rdata;
	logic db_request, db_rw, db_ready;
	soc_pkg::word_t db_address, db_wdata, db_rdata;
	logic ext_irq, interrupt;
	logic [7:0] leds;

	tag_t step_op [MAX_STEPS];
	tag_t step_port [MAX_STEPS];
	tag_t step_name [MAX_STEPS];
	soc_pkg::word_t step_addr [MAX_STEPS];
	soc_pkg::word_t step_data [MAX_STEPS];
	soc_pkg::word_t step_expected [MAX_STEPS];
	int num_steps = 0;

	soc_pkg::word_t sweep_words [16];
	soc_pkg::word_t lcg_state = 32'hf12f;
	int tests_run = 0;
	int tests_failed = 0;
	logic step_bad;
	int cycles = 0;
	int limit = 2000;

	soc_fabric i_dut (
		.clock(clock), .i_rst_n(rst_n),
		.i_ia_request(ia_request), .i_ia_address(ia_address),
		.o_ia_ready(ia_ready), .o_ia_rdata(ia_rdata),
		.i_db_request(db_request), .i_db_rw(db_rw),
		.i_db_address(db_address), .i_db_wdata(db_wdata),
		.o_db_ready(db_ready), .o_db_rdata(db_rdata),
		.i_ext_irq(ext_irq), .o_interrupt(interrupt), .o_leds(leds)
	);

	always #10 clock = ~clock;

	// Run length bound from the number of steps
	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("Timeout: the run did not finish within %0d cycles", limit);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	function automatic soc_pkg::word_t lcg_next(input soc_pkg::word_t state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check_word(input tag_t name, input soc_pkg::word_t expected,
			input soc_pkg::word_t actual);
		if (actual !== expected) begin
			$display("FAIL %0s expected %h actual %h", name, expected, actual);
			step_bad = 1'b1;
		end
	endtask

	// ========================================
	// Bus handshake on one or both ports
	// ========================================

	task automatic bus_transfer(input logic use_a, input soc_pkg::word_t a_addr,
			input logic use_b, input logic b_rw, input soc_pkg::word_t b_addr,
			input soc_pkg::word_t b_wdata,
			output soc_pkg::word_t a_rdata, output soc_pkg::word_t b_rdata);
		logic a_seen, b_seen;
		a_seen = 1'b0;
		b_seen = 1'b0;
		a_rdata = '0;
		b_rdata = '0;
		@(negedge clock);
		ia_request = use_a;
		ia_address = a_addr;
		db_request = use_b;
		db_rw = b_rw;
		db_address = b_addr;
		db_wdata = b_wdata;
		// Request drops in the cycle after ready
		while (ia_request || db_request) begin
			@(negedge clock);
			if (a_seen) begin
				ia_request = 1'b0;
			end else if (ia_request && ia_ready) begin
				a_rdata = ia_rdata;
				a_seen = 1'b1;
			end
			if (b_seen) begin
				db_request = 1'b0;
			end else if (db_request && db_ready) begin
				b_rdata = db_rdata;
				b_seen = 1'b1;
			end
		end
	endtask

	// Writes through port B, reads back through port A
	task automatic ram_sweep(input tag_t name, input soc_pkg::word_t base,
			input soc_pkg::word_t count);
		soc_pkg::word_t a_rd, b_rd;
		for (int i = 0; i < int'(count) && i < 16; i++) begin
			lcg_state = lcg_next(lcg_state);
			sweep_words[i] = lcg_state;
			bus_transfer(1'b0, '0, 1'b1, 1'b1, base + 32'(4 * i), lcg_state, a_rd, b_rd);
		end
		for (int i = 0; i < int'(count) && i < 16; i++) begin
			bus_transfer(1'b1, base + 32'(4 * i), 1'b0, 1'b0, '0, '0, a_rd, b_rd);
			check_word(name, sweep_words[i], a_rd);
		end
	endtask

	task automatic run_step(input int idx);
		tag_t op, port, name;
		soc_pkg::word_t addr, data, expected, a_rd, b_rd;
		logic is_check;
		int waited;
		op = step_op[idx];
		port = step_port[idx];
		name = step_name[idx];
		addr = step_addr[idx];
		data = step_data[idx];
		expected = step_expected[idx];
		step_bad = 1'b0;
		is_check = 1'b1;
		waited = 0;
		if (op == tag_t'("write")) begin
			bus_transfer(1'b0, '0, 1'b1, 1'b1, addr, data, a_rd, b_rd);
			is_check = 1'b0;
		end else if (op == tag_t'("read")) begin
			if (port == tag_t'("a")) begin
				bus_transfer(1'b1, addr, 1'b0, 1'b0, '0, '0, a_rd, b_rd);
				check_word(name, expected, a_rd);
			end else begin
				bus_transfer(1'b0, '0, 1'b1, 1'b0, addr, '0, a_rd, b_rd);
				check_word(name, expected, b_rd);
			end
		end else if (op == tag_t'("dual")) begin
			// B writes at addr while A reads the next word
			bus_transfer(1'b1, addr + 32'd4, 1'b1, 1'b1, addr, data, a_rd, b_rd);
			check_word(name, expected, a_rd);
		end else if (op == tag_t'("sweep")) begin
			ram_sweep(name, addr, data);
		end else if (op == tag_t'("wrap")) begin
			bus_transfer(1'b1, addr + 32'(`SOC_RAM_WORDS * 4), 1'b0, 1'b0, '0, '0,
				a_rd, b_rd);
			check_word(name, sweep_words[0], a_rd);
		end else if (op == tag_t'("leds")) begin
			@(negedge clock);
			check_word(name, expected, {24'd0, leds});
		end else if (op == tag_t'("irq")) begin
			@(negedge clock);
			check_word(name, expected, {31'd0, interrupt});
		end else if (op == tag_t'("waitirq")) begin
			while (!interrupt && waited < int'(data)) begin
				@(negedge clock);
				waited++;
			end
			check_word(name, expected, {31'd0, interrupt});
		end else if (op == tag_t'("setext")) begin
			// Hold the level across one rising edge
			@(negedge clock);
			ext_irq = data[0];
			@(negedge clock);
			is_check = 1'b0;
		end else begin
			$display("Unknown operation %0s in step %0s", op, name);
			step_bad = 1'b1;
		end
		if (is_check || step_bad) begin
			tests_run++;
			if (step_bad)
				tests_failed++;
			else
				$display("PASS %0s", name);
		end
	endtask

	// Lines that do not give all six fields are skipped
	task automatic load_tests();
		logic [8*160-1:0] line;
		tag_t op, port, name;
		soc_pkg::word_t addr, data, expected;
		int fd, got, fields;
		fd = $fopen("soc_fabric_tests.txt", "r");
		if (fd != 0) begin
			while (!$feof(fd) && num_steps < MAX_STEPS) begin
				line = '0;
				got = $fgets(line, fd);
				if (got > 0) begin
					fields = $sscanf(line, "%s %s %h %h %h %s", op, port, addr, data,
						expected, name);
					if (fields == 6) begin
						step_op[num_steps] = op;
						step_port[num_steps] = port;
						step_addr[num_steps] = addr;
						step_data[num_steps] = data;
						step_expected[num_steps] = expected;
						step_name[num_steps] = name;
						num_steps++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// ========================================
	// Main sequence
	// ========================================

	initial begin
		rst_n = 1'b0;
		ia_request = 1'b0;
		ia_address = '0;
		db_request = 1'b0;
		db_rw = 1'b0;
		db_address = '0;
		db_wdata = '0;
		ext_irq = 1'b0;
		load_tests();
		limit = num_steps * 64 + 2000;
		if (num_steps == 0) begin
			$display("No test steps could be read from soc_fabric_tests.txt");
			$display("CHECKS FAILED");
			$finish;
		end else begin
			repeat (8) @(negedge clock);
			rst_n = 1'b1;
			for (int i = 0; i < num_steps; i++)
				run_step(i);
			$display("%0d tests run, %0d failed", tests_run, tests_failed);
			if (tests_failed == 0)
				$display("ALL CHECKS PASSED");
			else
				$display("CHECKS FAILED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== soc_fabric_tests.txt ====
# op port address data expected name (address, data and expected in hex)
# sweep: data is the word count; wrap: address is the sweep base; dual: A reads address+4
sweep   b 20000000 00000010 00000000 ram_sweep
wrap    a 20000000 00000000 00000000 ram_wrap
write   b 20000104 cafe0001 00000000 dual_setup
dual    - 20000100 12345678 cafe0001 dual_read_a
read    a 20000100 00000000 12345678 dual_write_b
read    b 20000104 00000000 cafe0001 dual_read_back
read    a 59000000 00000000 00000006 sysreg_id
read    b 59000004 00000000 00000400 sysreg_ram_size
write   b 59000008 000000a5 00000000 leds_write
leds    - 00000000 00000000 000000a5 leds_output
read    a 59000008 00000000 000000a5 leds_read
write   b 5900000c deadbeef 00000000 scratch_write
read    b 5900000c 00000000 deadbeef scratch_read
write   b 59000000 00000055 00000000 id_write
read    a 59000000 00000000 00000006 id_unchanged
write   b 58000004 00000001 00000000 enable_timer
write   b 55000000 00000000 00000000 timer_counter
write   b 55000004 0000012c 00000000 timer_compare
read    b 55000004 00000000 0000012c timer_compare_read
read    b 58000000 00000000 00000000 pending_before_irq
waitirq - 00000000 00000190 00000001 timer_irq_rise
read    b 58000000 00000000 00000001 pending_timer
write   b 58000000 00000001 00000000 pending_clear
write   b 55000004 00000000 00000000 timer_compare_off
irq     - 00000000 00000000 00000000 timer_irq_cleared
read    b 58000000 00000000 00000000 pending_after_clear
write   b 58000004 00000000 00000000 enable_off
setext  - 00000000 00000001 00000000 ext_high
setext  - 00000000 00000000 00000000 ext_low
read    b 58000000 00000000 00000002 pending_ext
irq     - 00000000 00000000 00000000 ext_masked
write   b 58000004 00000002 00000000 enable_ext
irq     - 00000000 00000000 00000001 ext_unmasked
read    a 70000000 00000000 00000000 unmapped_near
read    b 53000000 00000000 00000000 unmapped_far

// ==== src.f ====
+incdir+.
soc_pkg.sv
bus_arbiter.sv
near_bus.sv
far_bridge.sv
interval_timer.sv
interrupt_controller.sv
system_registers.sv
soc_fabric.sv
tb_soc_fabric.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 --top-module tb_soc_fabric -f src.f
output=$(./obj_dir/Vtb_soc_fabric)
echo "$output"
if echo "$output" | grep -q "ALL CHECKS PASSED"; then
	exit 0
else
	exit 1
fi
